//--- rtl/data_array.sv
`timescale 1ns/1ps
`include "dcache_defines.svh"

module data_array (
    input  logic                clk,
    input  logic                rst,
    input  dcache_pkg::index_t  index,
    input  dcache_pkg::offset_t offset,
    input  dcache_pkg::way_t    way,
    input  dcache_pkg::way_t    fill_way,
    input  logic                fill_en,
    input  dcache_pkg::line_t   fill_line,
    input  logic                store_en,
    input  dcache_pkg::strb_t   strb,
    input  dcache_pkg::word_t   wdata,
    output dcache_pkg::word_t   word,
    output dcache_pkg::line_t   victim_line
);
    import dcache_pkg::*;

    line_t                 lines_q [`DC_WAYS][`DC_SETS];
    logic [`DC_WSEL_W-1:0] wsel;
    word_t                 merged;

    assign wsel        = offset[`DC_OFFSET_W-1:2];
    assign word        = lines_q[way][index][wsel];
    assign victim_line = lines_q[fill_way][index];

    // strobed bytes over the current word
    always_comb begin
        merged = word;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                merged[8*b +: 8] = wdata[8*b +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            if (fill_en) begin
                lines_q[fill_way][index] <= fill_line;
            end else if (store_en) begin
                lines_q[way][index][wsel] <= merged;   // single word touched
            end
        end
    end

endmodule

//--- rtl/dcache_ctrl.sv
`timescale 1ns/1ps
`include "dcache_defines.svh"

module dcache_ctrl (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    req_valid,
    input  dcache_pkg::cpu_req_t    req,
    input  logic                    hit,
    input  logic                    victim_dirty,
    input  dcache_pkg::tag_t        victim_tag,
    input  dcache_pkg::line_t       victim_line,
    input  logic                    mem_rdy,
    input  logic                    mem_ret_valid,
    output dcache_pkg::ctrl_state_e state,
    output logic                    mem_valid,
    output dcache_pkg::mem_req_t    mem_req,
    output logic                    fill_en,
    output logic                    store_en,
    output logic                    lru_touch,
    output logic                    busy,
    output logic                    resp_valid
);
    import dcache_pkg::*;

    ctrl_state_e state_next;
    index_t      idx;
    logic        hit_now;

    assign idx     = req.addr[`DC_OFFSET_W +: `DC_INDEX_W];
    assign hit_now = (state == LOOKUP) && req_valid && req.cached && hit;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= LOOKUP;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            LOOKUP: begin
                if (req_valid && !req.cached) begin
                    state_next = UNC_REQ;
                end else if (req_valid && !hit) begin
                    state_next = victim_dirty ? WB_REQ : FILL_REQ;   // old line goes out first
                end
            end
            WB_REQ:    state_next = mem_rdy ? WB_WAIT : WB_REQ;
            WB_WAIT:   state_next = mem_ret_valid ? FILL_REQ : WB_WAIT;
            FILL_REQ:  state_next = mem_rdy ? FILL_WAIT : FILL_REQ;
            FILL_WAIT: state_next = mem_ret_valid ? FILL_DONE : FILL_WAIT;
            UNC_REQ:   state_next = mem_rdy ? UNC_WAIT : UNC_REQ;
            UNC_WAIT:  state_next = mem_ret_valid ? UNC_DONE : UNC_WAIT;
            default:   state_next = LOOKUP;   // fill_done, unc_done
        endcase
    end

    always_comb begin
        mem_req      = '0;
        mem_req.strb = '1;
        case (state)
            WB_REQ: begin
                mem_req.op   = MEM_LINE_WR;
                mem_req.addr = {victim_tag, idx, offset_t'(0)};
                mem_req.data = victim_line;
            end
            UNC_REQ: begin
                mem_req.op      = req.write ? MEM_WORD_WR : MEM_WORD_RD;
                mem_req.addr    = {req.addr[`DC_ADDR_W-1:2], 2'b00};
                mem_req.strb    = req.write ? req.strb : '1;
                mem_req.data[0] = req.wdata;
            end
            default: begin
                mem_req.op   = MEM_LINE_RD;
                mem_req.addr = {req.addr[`DC_ADDR_W-1:`DC_OFFSET_W], offset_t'(0)};
            end
        endcase
    end

    assign mem_valid = (state == WB_REQ) || (state == FILL_REQ) || (state == UNC_REQ);

    // open miss or uncached access holds off the processor
    assign busy = (state != LOOKUP) || (req_valid && !(req.cached && hit));

    assign resp_valid = hit_now || (state == FILL_DONE) || (state == UNC_DONE);
    assign lru_touch  = hit_now || (state == FILL_DONE);
    assign store_en   = (hit_now || (state == FILL_DONE)) && req.write;
    assign fill_en    = (state == FILL_WAIT) && mem_ret_valid;

endmodule

//--- rtl/dcache_defines.svh
`ifndef DCACHE_DEFINES_SVH
`define DCACHE_DEFINES_SVH

`define DC_SETS       16
`define DC_LINE_WORDS 4
`define DC_WAYS       2     // one lru bit per set
`define DC_ADDR_W     32

`define DC_WORD_W     32

// widths derived from the geometry above
`define DC_OFFSET_W   ($clog2(`DC_LINE_WORDS * 4))
`define DC_INDEX_W    ($clog2(`DC_SETS))
`define DC_TAG_W      (`DC_ADDR_W - `DC_INDEX_W - `DC_OFFSET_W)
`define DC_WSEL_W     ($clog2(`DC_LINE_WORDS))

`endif

//--- rtl/dcache_pkg.sv
`include "dcache_defines.svh"

package dcache_pkg;

    typedef logic [`DC_ADDR_W-1:0]        addr_t;
    typedef logic [`DC_WORD_W-1:0]        word_t;
    typedef logic [`DC_TAG_W-1:0]         tag_t;
    typedef logic [`DC_INDEX_W-1:0]       index_t;
    typedef logic [`DC_OFFSET_W-1:0]      offset_t;
    typedef logic [$clog2(`DC_WAYS)-1:0]  way_t;
    typedef logic [3:0]                   strb_t;
    typedef word_t [`DC_LINE_WORDS-1:0]   line_t;     // word 0 in the low bits

    typedef enum logic [2:0] {
        LW, LH, LHU, LB, LBU
    } load_size_e;

    typedef enum logic [1:0] {
        MEM_LINE_RD,
        MEM_LINE_WR,
        MEM_WORD_RD,
        MEM_WORD_WR
    } mem_op_e;

    typedef struct packed {
        logic       write;
        logic       cached;
        addr_t      addr;
        strb_t      strb;
        word_t      wdata;
        load_size_e size;
    } cpu_req_t;

    typedef struct packed {
        mem_op_e op;
        addr_t   addr;
        strb_t   strb;
        line_t   data;     // word ops use data[0]
    } mem_req_t;

    typedef enum logic [3:0] {
        LOOKUP, WB_REQ, WB_WAIT, FILL_REQ, FILL_WAIT, FILL_DONE,
        UNC_REQ, UNC_WAIT, UNC_DONE
    } ctrl_state_e;

endpackage

//--- rtl/dcache_top.sv
`timescale 1ns/1ps
`include "dcache_defines.svh"

module dcache_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cpu_valid,
    input  dcache_pkg::cpu_req_t cpu_req,
    output logic                 cpu_ready,
    output logic                 resp_valid,
    output dcache_pkg::word_t    rdata,
    output logic                 mem_valid,
    output dcache_pkg::mem_req_t mem_req,
    input  logic                 mem_rdy,
    input  logic                 mem_ret_valid,
    input  dcache_pkg::line_t    mem_ret_data
);
    import dcache_pkg::*;

    logic        req_valid;
    cpu_req_t    req_q;
    word_t       unc_word;
    ctrl_state_e state;
    logic        busy;
    logic        hit;
    logic        victim_dirty;
    logic        fill_en;
    logic        store_en;
    logic        lru_touch;
    way_t        hit_way;
    way_t        victim_way;
    way_t        read_way;
    tag_t        victim_tag;
    line_t       victim_line;
    word_t       arr_word;
    word_t       final_word;
    word_t       aligned;

    assign cpu_ready = !busy;

    always_ff @(posedge clk) begin
        if (rst) begin
            req_valid <= 1'b0;
        end else if (cpu_valid && cpu_ready) begin
            req_valid <= 1'b1;   // next request replaces the answered one
        end else if (resp_valid) begin
            req_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (cpu_valid && cpu_ready) begin
            req_q <= cpu_req;
        end
        if ((state == UNC_WAIT) && mem_ret_valid) begin
            unc_word <= mem_ret_data[0];
        end
    end

    assign read_way   = (state == FILL_DONE) ? victim_way : hit_way;
    assign final_word = (state == UNC_DONE) ? unc_word : arr_word;
    assign rdata      = req_q.write ? '0 : aligned;

    dcache_ctrl u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .req_valid    (req_valid),
        .req          (req_q),
        .hit          (hit),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .victim_line  (victim_line),
        .mem_rdy      (mem_rdy),
        .mem_ret_valid(mem_ret_valid),
        .state        (state),
        .mem_valid    (mem_valid),
        .mem_req      (mem_req),
        .fill_en      (fill_en),
        .store_en     (store_en),
        .lru_touch    (lru_touch),
        .busy         (busy),
        .resp_valid   (resp_valid)
    );

    tag_array u_tags (
        .clk         (clk),
        .rst         (rst),
        .index       (req_q.addr[`DC_OFFSET_W +: `DC_INDEX_W]),
        .tag         (req_q.addr[`DC_ADDR_W-1 -: `DC_TAG_W]),
        .fill_en     (fill_en),
        .store_en    (store_en),
        .lru_touch   (lru_touch),
        .hit         (hit),
        .hit_way     (hit_way),
        .victim_way  (victim_way),
        .victim_dirty(victim_dirty),
        .victim_tag  (victim_tag)
    );

    data_array u_data (
        .clk        (clk),
        .rst        (rst),
        .index      (req_q.addr[`DC_OFFSET_W +: `DC_INDEX_W]),
        .offset     (req_q.addr[`DC_OFFSET_W-1:0]),
        .way        (read_way),
        .fill_way   (victim_way),
        .fill_en    (fill_en),
        .fill_line  (mem_ret_data),
        .store_en   (store_en),
        .strb       (req_q.strb),
        .wdata      (req_q.wdata),
        .word       (arr_word),
        .victim_line(victim_line)
    );

    load_align u_align (
        .word  (final_word),
        .offset(req_q.addr[`DC_OFFSET_W-1:0]),
        .size  (req_q.size),
        .rdata (aligned)
    );

endmodule

//--- rtl/load_align.sv
`timescale 1ns/1ps

module load_align (
    input  dcache_pkg::word_t      word,
    input  dcache_pkg::offset_t    offset,
    input  dcache_pkg::load_size_e size,
    output dcache_pkg::word_t      rdata
);
    import dcache_pkg::*;

    logic [15:0] half_val;
    logic [7:0]  byte_val;

    assign half_val = offset[1] ? word[31:16] : word[15:0];
    assign byte_val = word[8*offset[1:0] +: 8];

    always_comb begin
        case (size)
            LH:      rdata = {{16{half_val[15]}}, half_val};
            LHU:     rdata = {16'b0, half_val};
            LB:      rdata = {{24{byte_val[7]}}, byte_val};
            LBU:     rdata = {24'b0, byte_val};
            default: rdata = word;   // full word
        endcase
    end

endmodule

//--- rtl/tag_array.sv
`timescale 1ns/1ps
`include "dcache_defines.svh"

module tag_array (
    input  logic               clk,
    input  logic               rst,
    input  dcache_pkg::index_t index,
    input  dcache_pkg::tag_t   tag,
    input  logic               fill_en,
    input  logic               store_en,
    input  logic               lru_touch,
    output logic               hit,
    output dcache_pkg::way_t   hit_way,
    output dcache_pkg::way_t   victim_way,
    output logic               victim_dirty,
    output dcache_pkg::tag_t   victim_tag
);
    import dcache_pkg::*;

    logic [`DC_SETS-1:0][`DC_WAYS-1:0] valid_q;
    logic [`DC_SETS-1:0][`DC_WAYS-1:0] dirty_q;
    logic [`DC_SETS-1:0]               lru_q;     // least recently used way
    tag_t                              tag_q [`DC_WAYS][`DC_SETS];
    logic [`DC_WAYS-1:0]               way_hit;

    always_comb begin
        for (int w = 0; w < `DC_WAYS; w++) begin
            way_hit[w] = valid_q[index][w] && (tag_q[w][index] == tag);
        end
    end

    assign hit     = |way_hit;
    assign hit_way = way_hit[1];

    // empty ways come up first, every fill points lru away
    assign victim_way = lru_q[index];

    assign victim_dirty = valid_q[index][victim_way] && dirty_q[index][victim_way];
    assign victim_tag   = tag_q[victim_way][index];

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
            lru_q   <= '0;
        end else begin
            if (fill_en) begin
                valid_q[index][victim_way] <= 1'b1;
            end
            if (lru_touch) begin
                lru_q[index] <= ~hit_way;   // other way becomes lru
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill_en) begin
            tag_q[victim_way][index]   <= tag;
            dirty_q[index][victim_way] <= 1'b0;   // refilled line is clean
        end else if (store_en) begin
            dirty_q[index][hit_way] <= 1'b1;
        end
    end

endmodule

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    -f verilog.f --top-module tb_dcache -o tb_dcache_sim
./obj_dir/tb_dcache_sim | tee sim.log
grep -q "^Simulation passed$" sim.log
echo "run_sim: pass message found in sim.log"

//--- tests/dcache_assertions.sv
`timescale 1ns/1ps

module dcache_assertions (
    input logic                    clk,
    input logic                    rst,
    input logic                    cpu_valid,
    input logic                    cpu_ready,
    input logic                    resp_valid,
    input logic                    mem_valid,
    input logic                    mem_rdy,
    input dcache_pkg::mem_req_t    mem_req,
    input dcache_pkg::ctrl_state_e state
);
    import dcache_pkg::*;

    int unsigned pending;   // accepted, not yet answered

    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= 0;
        end else begin
            pending <= pending + 32'(cpu_valid && cpu_ready) - 32'(resp_valid);
        end
    end

    mem_req_held: assert property (@(posedge clk) disable iff (rst)
        mem_valid && !mem_rdy |=> mem_valid && $stable(mem_req))
        else $error("mem_req changed before mem_rdy");

    one_resp_per_req: assert property (@(posedge clk) disable iff (rst)
        resp_valid |-> pending != 0)
        else $error("resp_valid without an accepted request");

    // ready only in a lookup that stays in lookup
    ready_in_lookup: assert property (@(posedge clk) disable iff (rst)
        cpu_ready |=> $past(state) == LOOKUP && state == LOOKUP)
        else $error("cpu_ready high outside LOOKUP or in a miss lookup");

endmodule

bind dcache_top dcache_assertions u_assertions (
    .clk       (clk),
    .rst       (rst),
    .cpu_valid (cpu_valid),
    .cpu_ready (cpu_ready),
    .resp_valid(resp_valid),
    .mem_valid (mem_valid),
    .mem_rdy   (mem_rdy),
    .mem_req   (mem_req),
    .state     (state)
);

//--- tests/tb_dcache.sv
`timescale 1ns/1ps
`include "dcache_defines.svh"

module tb_dcache;
    import dcache_pkg::*;

    localparam int NUM_REQS   = 600;
    localparam int OFF_W      = `DC_OFFSET_W;
    localparam int TAG_LO     = `DC_OFFSET_W + `DC_INDEX_W;
    localparam int LINE_BYTES = `DC_LINE_WORDS * 4;

    typedef struct packed {
        logic  first_fill;   // first touch of the line, must refill
        word_t value;
    } expect_t;

    logic     clk = 1'b0;
    logic     rst;
    logic     cpu_valid;
    cpu_req_t cpu_req;
    logic     cpu_ready;
    logic     resp_valid;
    word_t    rdata;
    logic     mem_valid;
    mem_req_t mem_req;
    logic     mem_rdy;
    logic     mem_ret_valid;
    line_t    mem_ret_data;

    integer     seed = 32'h2732_1f64;
    logic [7:0] mem_bytes [addr_t];   // memory model contents
    logic [7:0] shadow [addr_t];      // updated at issue
    bit         lines_seen [addr_t];
    expect_t    exp_q [$];
    cpu_req_t   last_req;
    int         line_rd_seen;
    int         line_wr_seen;
    int         word_seen;
    int         resp_count;

    dcache_top DUT (
        .clk          (clk),
        .rst          (rst),
        .cpu_valid    (cpu_valid),
        .cpu_req      (cpu_req),
        .cpu_ready    (cpu_ready),
        .resp_valid   (resp_valid),
        .rdata        (rdata),
        .mem_valid    (mem_valid),
        .mem_req      (mem_req),
        .mem_rdy      (mem_rdy),
        .mem_ret_valid(mem_ret_valid),
        .mem_ret_data (mem_ret_data)
    );

    always #4 clk = ~clk;

    function automatic logic [7:0] fill_byte(input addr_t a);
        word_t h;
        h = a * 32'h9e37_79b1;   // hash over all address bits
        return h[31:24] ^ h[15:8];
    endfunction

    function automatic logic [7:0] model_byte(input addr_t a);
        return mem_bytes.exists(a) ? mem_bytes[a] : fill_byte(a);
    endfunction

    function automatic logic [7:0] shadow_byte(input addr_t a);
        return shadow.exists(a) ? shadow[a] : fill_byte(a);
    endfunction

    function automatic addr_t line_base(input addr_t a);
        return a & ~addr_t'(LINE_BYTES - 1);
    endfunction

    // expected load result straight from the shadow bytes
    function automatic word_t expected_load(input addr_t a, input load_size_e size);
        word_t       w;
        logic [15:0] h;
        logic [7:0]  b;
        for (int i = 0; i < 4; i++) begin
            w[8*i +: 8] = shadow_byte({a[31:2], 2'b00} + addr_t'(i));
        end
        h = {shadow_byte({a[31:1], 1'b1}), shadow_byte({a[31:1], 1'b0})};
        b = shadow_byte(a);
        case (size)
            LW:      return w;
            LH:      return {{16{h[15]}}, h};
            LHU:     return {16'h0, h};
            LB:      return {{24{b[7]}}, b};
            default: return {24'h0, b};
        endcase
    endfunction

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("ERROR at %0t ns: %s, got %08h, expected %08h",
                     $time, what, actual, expected);
            $display("Simulation failed");
            $fatal(1, "check failed");
        end
    endtask

    task automatic make_request(output cpu_req_t r);
        int unsigned tsel;
        int unsigned idx;
        int unsigned off;
        r        = '0;
        tsel     = $unsigned($random(seed)) % 3;    // three tags per set
        idx      = $unsigned($random(seed)) % 4;
        off      = $unsigned($random(seed)) % LINE_BYTES;
        r.cached = ($unsigned($random(seed)) % 8) != 0;
        r.write  = ($unsigned($random(seed)) % 3) == 0;
        r.strb   = strb_t'($random(seed));
        r.wdata  = $random(seed);
        r.size   = load_size_e'($unsigned($random(seed)) % 5);
        if (r.cached) begin
            r.addr = addr_t'((tsel << 12) | (idx << OFF_W) | off);
        end else begin
            r.addr = 32'h8000_0000 | addr_t'($unsigned($random(seed)) % 64);
        end
    endtask

    // one accepted memory request, with its return data
    task automatic serve_request(input mem_req_t op, output line_t ret);
        addr_t a;
        ret = '0;
        case (op.op)
            MEM_LINE_RD: begin
                check_equal(last_req.cached, 1'b1, "line read for an uncached access");
                check_equal(op.addr, line_base(last_req.addr), "line read address");
                check_equal(line_rd_seen, 0, "second line read for one miss");
                line_rd_seen++;
                for (int i = 0; i < LINE_BYTES; i++) begin
                    ret[i/4][8*(i%4) +: 8] = model_byte(op.addr + addr_t'(i));
                end
            end
            MEM_LINE_WR: begin
                check_equal(last_req.cached, 1'b1, "line write for an uncached access");
                check_equal(line_rd_seen + line_wr_seen, 0, "writeback out of order");
                check_equal(op.addr[TAG_LO-1:OFF_W], last_req.addr[TAG_LO-1:OFF_W],
                            "writeback set index");
                check_equal(op.addr[OFF_W-1:0], 0, "writeback alignment");
                check_equal(op.addr[31:TAG_LO] != last_req.addr[31:TAG_LO], 1'b1,
                            "writeback of the requested tag");
                line_wr_seen++;
                for (int i = 0; i < LINE_BYTES; i++) begin
                    a = op.addr + addr_t'(i);
                    check_equal(op.data[i/4][8*(i%4) +: 8], shadow_byte(a), "writeback byte");
                    mem_bytes[a] = op.data[i/4][8*(i%4) +: 8];
                end
            end
            default: begin
                check_equal(last_req.cached, 1'b0, "word access for a cached request");
                check_equal(word_seen, 0, "second word access for one request");
                word_seen++;
                check_equal(op.addr, {last_req.addr[31:2], 2'b00}, "word address");
                check_equal(op.op, last_req.write ? MEM_WORD_WR : MEM_WORD_RD, "word op");
                if (last_req.write) begin
                    check_equal(op.strb, last_req.strb, "word write strobe");
                    check_equal(op.data[0], last_req.wdata, "word write data");
                end
                for (int i = 0; i < 4; i++) begin
                    a = op.addr + addr_t'(i);
                    if (op.op == MEM_WORD_WR && op.strb[i]) begin
                        mem_bytes[a] = op.data[0][8*i +: 8];
                    end
                    ret[0][8*i +: 8] = model_byte(a);
                end
            end
        endcase
    endtask

    initial begin : memory_model
        mem_req_t op;
        line_t    ret;
        int       delay;
        mem_rdy       = 1'b0;
        mem_ret_valid = 1'b0;
        mem_ret_data  = '0;
        forever begin
            @(negedge clk);
            mem_ret_valid = 1'b0;
            mem_rdy       = ($unsigned($random(seed)) % 3) == 0;   // random stalls
            if (!rst && mem_valid && mem_rdy) begin
                op = mem_req;
                serve_request(op, ret);
                @(negedge clk);   // accepted on the edge in between
                mem_rdy = 1'b0;
                delay   = $unsigned($random(seed)) % 5;
                repeat (delay) @(negedge clk);
                mem_ret_data  = ret;
                mem_ret_valid = 1'b1;
            end
        end
    end

    initial begin : compare_responses
        expect_t e;
        resp_count = 0;
        forever begin
            @(negedge clk);
            if (!rst && resp_valid) begin
                check_equal(exp_q.size() != 0, 1'b1, "response with nothing outstanding");
                e = exp_q.pop_front();
                check_equal(rdata, e.value, "response data");
                if (e.first_fill) begin
                    check_equal(line_rd_seen, 1, "line reads on first access of a line");
                end
                resp_count++;
            end
        end
    end

    initial begin : stimulus
        cpu_req_t r;
        expect_t  e;
        int       issued;
        rst          = 1'b1;
        cpu_valid    = 1'b0;
        cpu_req      = '0;
        last_req     = '0;
        line_rd_seen = 0;
        line_wr_seen = 0;
        word_seen    = 0;
        issued       = 0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_equal(mem_valid, 1'b0, "mem_valid after reset");
        check_equal(resp_valid, 1'b0, "resp_valid after reset");
        check_equal(cpu_ready, 1'b1, "cpu_ready after reset");
        while (issued < NUM_REQS) begin
            @(negedge clk);
            cpu_valid = 1'b0;
            if (cpu_ready && ($unsigned($random(seed)) % 8) != 0) begin
                make_request(r);
                e.first_fill = r.cached && !lines_seen.exists(line_base(r.addr));
                e.value      = r.write ? '0 : expected_load(r.addr, r.size);
                if (r.cached) begin
                    lines_seen[line_base(r.addr)] = 1'b1;
                end
                for (int i = 0; i < 4; i++) begin
                    if (r.write && r.strb[i]) begin
                        shadow[{r.addr[31:2], 2'b00} + addr_t'(i)] = r.wdata[8*i +: 8];
                    end
                end
                exp_q.push_back(e);
                last_req     = r;
                line_rd_seen = 0;
                line_wr_seen = 0;
                word_seen    = 0;
                cpu_req      = r;
                cpu_valid    = 1'b1;
                issued++;
            end
        end
        @(negedge clk);
        cpu_valid = 1'b0;
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);   // catch a stray extra response
        check_equal(resp_count, NUM_REQS, "response count");
        $display("Simulation passed");
        $finish;
    end

    initial begin : watchdog
        repeat (NUM_REQS * 200) @(posedge clk);
        $display("timeout, %0d responses never arrived", exp_q.size());
        $display("Simulation failed");
        $fatal(1, "watchdog expired");
    end

endmodule

//--- verilog.f
+incdir+rtl
rtl/dcache_pkg.sv
rtl/dcache_ctrl.sv
rtl/tag_array.sv
rtl/data_array.sv
rtl/load_align.sv
rtl/dcache_top.sv
tests/dcache_assertions.sv
tests/tb_dcache.sv
